//--- bench/led_matrix_chk.sv
//****************************************
// panel and SPI protocol assertions, bound to led_matrix_top
//****************************************
`timescale 1ns/10ps

module led_matrix_chk (
	input logic clk,
	input logic rst,
	input logic latch,
	input logic display_oe,
	input logic display_clk,
	input logic spi_clk,
	input logic cs_n
);

	// no latch while the row is lit
	latch_vs_oe: assert property (@(posedge clk) disable iff (rst) latch |-> display_oe)
		else $error("latch high while display_oe is low");

	shift_vs_latch: assert property (@(posedge clk) disable iff (rst) latch |-> !display_clk)
		else $error("display_clk high during latch");

	// mode 3 idles high
	spi_idle: assert property (@(posedge clk) disable iff (rst) cs_n |-> spi_clk)
		else $error("spi_clk low while cs_n is high");

endmodule

bind led_matrix_top led_matrix_chk u_chk (
	.clk(clk), .rst(rst), .latch(latch), .display_oe(display_oe),
	.display_clk(display_clk), .spi_clk(spi_clk), .cs_n(cs_n)
);

//--- bench/led_matrix_trace.txt
# W <byte addr> <write data> <expected pslverr>, R <byte addr> <expected data> <expected pslverr>
# P <five pad response bytes>, then wait for one complete poll with them
R 4000 00000000 0
W 0000 00000005 0
W 00fc 0000000c 0
W 2000 00000003 0
W 1f04 00000009 0
W 3f7c 0000000a 0
W 0508 12345677 0
W 2a40 00000000 0
W 8000 0000000a 1
W 4000 0000ffff 1
R 0004 00000000 1
R 8000 00000000 1
P ff 41 5a 7e bd
R 4000 00008142 0
W 4000 00001234 1
R 4000 00008142 0
P 00 41 5a 00 01
R 4000 0000fffe 0

//--- bench/tb_led_matrix.sv
//****************************************
// replays bench/led_matrix_trace.txt, run from the project root
// pixels are compared only once written, a full run takes about 0.25 ms
//****************************************
`timescale 1ns/10ps
`include "led_matrix_config.svh"

module tb_led_matrix;

	localparam int PIX_N         = `LED_ROWS * `LED_COLS;
	localparam int APB_TIMEOUT   = 16;
	localparam int POLL_TIMEOUT  = 40000;   // one poll in flight plus a full one
	localparam int FRAME_TIMEOUT = 20000;
	localparam int POLL_BITS     = `PAD_REQ_BYTES * 8;

	logic                      clk;
	logic                      rst;
	led_matrix_pkg::apb_addr_t paddr;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	led_matrix_pkg::apb_data_t pwdata;
	led_matrix_pkg::apb_data_t prdata;
	logic                      pready;
	logic                      pslverr;
	led_matrix_pkg::row_t      row_addr;
	led_matrix_pkg::col_t      col_addr;
	logic                      display_oe;
	logic                      latch;
	logic                      display_clk;
	led_matrix_pkg::pixel_t    dout_a;
	led_matrix_pkg::pixel_t    dout_b;
	logic                      spi_clk;
	logic                      cs_n;
	logic                      mosi;
	logic                      miso;

	// expected panel contents, [0] upper half, [1] lower half
	led_matrix_pkg::pixel_t    exp_pix [2][PIX_N];
	logic                      pix_written [2][PIX_N];
	logic                      pix_seen [2][PIX_N];
	time                       pix_time [2][PIX_N];
	led_matrix_pkg::spi_byte_t pad_bytes [`PAD_REQ_BYTES];
	led_matrix_pkg::spi_byte_t req_bytes [`PAD_REQ_BYTES];
	led_matrix_pkg::spi_byte_t mosi_byte;
	led_matrix_pkg::row_t      cur_row;
	int col_cnt, latch_cnt, oe_cnt, frames;
	int polls_started, polls_done, spi_bits, miso_bits;
	logic dclk_q, latch_q, oe_q, spi_q, cs_q;

	led_matrix_top uut (
		.clk(clk), .rst(rst),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.row_addr(row_addr), .col_addr(col_addr), .display_oe(display_oe),
		.latch(latch), .display_clk(display_clk), .dout_a(dout_a), .dout_b(dout_b),
		.spi_clk(spi_clk), .cs_n(cs_n), .mosi(mosi), .miso(miso)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "simulation stopped after the first error");
	endtask

	task automatic check_pixel(input led_matrix_pkg::pixel_t got, exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("Mismatch at %0d ns: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_word(input led_matrix_pkg::apb_data_t got, exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("Mismatch at %0d ns: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_byte(input led_matrix_pkg::spi_byte_t got, exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("Mismatch at %0d ns: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_bit(input logic got, exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("Mismatch at %0d ns: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	task automatic check_row(input led_matrix_pkg::row_t got, exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("Mismatch at %0d ns: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_col(input led_matrix_pkg::col_t got, exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("Mismatch at %0d ns: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	// setup on one falling edge, access on the next, done at the rising edge with pready
	task automatic apb_access(input led_matrix_pkg::apb_addr_t addr, input logic write,
		input led_matrix_pkg::apb_data_t wdata, output led_matrix_pkg::apb_data_t rdata,
		output logic err);
		int waited;
		@(negedge clk);
		paddr   = addr;
		pwrite  = write;
		pwdata  = wdata;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		waited  = 0;
		while (pready !== 1'b1) begin
			@(negedge clk);
			waited++;
			if (waited > APB_TIMEOUT)
				stop_on_error("APB transfer never completed, pready stayed low");
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
	endtask

	task automatic bus_idle(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			psel    = 1'b0;
			penable = 1'b0;
		end
	endtask

	task automatic wait_poll();
		int target;
		int waited;
		target = polls_started + 1;   // a poll that starts from now on
		waited = 0;
		while (polls_done < target) begin
			@(negedge clk);
			waited++;
			if (waited > POLL_TIMEOUT)
				stop_on_error("no complete SPI poll of the game pad within the time limit");
		end
	endtask

	task automatic wait_frames(input int n);
		int target;
		int waited;
		target = frames + n;
		waited = 0;
		while (frames < target) begin
			@(negedge clk);
			waited++;
			if (waited > FRAME_TIMEOUT * n)
				stop_on_error("panel scan did not complete its frames in time");
		end
	endtask

	task automatic compare_pixels();
		int idx;
		string where;
		idx   = int'({row_addr, col_addr});
		where = $sformatf("pixel at row %0d col %0d", row_addr, col_addr);
		// a fetch in flight at the write edge still shows the old pixel
		if (pix_written[0][idx] && $time > pix_time[0][idx] + 16) begin
			check_pixel(dout_a, exp_pix[0][idx], {"dout_a ", where});
			pix_seen[0][idx] = 1'b1;
		end
		if (pix_written[1][idx] && $time > pix_time[1][idx] + 16) begin
			check_pixel(dout_b, exp_pix[1][idx], {"dout_b ", where});
			pix_seen[1][idx] = 1'b1;
		end
	endtask

	task automatic replay_trace();
		int fd;
		int h;
		string line;
		byte kind;
		logic [31:0] f1, f2, f3, f4, f5;
		led_matrix_pkg::apb_data_t rdata;
		logic err;
		fd = $fopen("bench/led_matrix_trace.txt", "r");
		if (fd == 0)
			stop_on_error("cannot open bench/led_matrix_trace.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			kind = line.getc(0);
			void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h", f1, f2, f3, f4, f5));
			case (kind)
				"W": begin
					apb_access(f1[15:0], 1'b1, f2, rdata, err);
					check_bit(err, f3[0], $sformatf("pslverr of write to %h", f1[15:0]));
					// framebuffer map: bit 13 half, 12..8 row, 7..2 col
					if (!f3[0] && f1[15:14] == 2'b00) begin
						h = int'(f1[13]);
						exp_pix[h][f1[12:2]]     = f2[`PIXEL_W-1:0];
						pix_written[h][f1[12:2]] = 1'b1;
						pix_time[h][f1[12:2]]    = $time;
					end
				end
				"R": begin
					apb_access(f1[15:0], 1'b0, '0, rdata, err);
					check_bit(err, f3[0], $sformatf("pslverr of read from %h", f1[15:0]));
					check_word(rdata, f2, $sformatf("prdata from %h", f1[15:0]));
				end
				"P": begin
					pad_bytes[0] = f1[7:0];
					pad_bytes[1] = f2[7:0];
					pad_bytes[2] = f3[7:0];
					pad_bytes[3] = f4[7:0];
					pad_bytes[4] = f5[7:0];
					wait_poll();
				end
				default: stop_on_error({"unknown line in trace file: ", line});
			endcase
			bus_idle(1 + int'($urandom % 4));
		end
		$fclose(fd);
	endtask

	// panel monitor, everything sampled on the falling clk edge
	always @(negedge clk) begin
		if (!rst) begin
			if (display_clk && !dclk_q) begin
				check_row(row_addr, cur_row, "row_addr during column shift");
				check_col(col_addr, led_matrix_pkg::col_t'(col_cnt), "col_addr order");
				compare_pixels();
				col_cnt++;
			end
			if (latch && !latch_q) begin
				check_bit(col_cnt == `LED_COLS, 1'b1, "latch after all 64 columns");
				latch_cnt++;
			end
			if (!display_oe && oe_q) begin
				check_bit(latch_cnt == 1, 1'b1, "one latch pulse before display_oe");
				oe_cnt++;
			end
			if (row_addr != cur_row) begin
				check_row(row_addr, led_matrix_pkg::row_t'(cur_row + 5'd1), "row_addr step");
				check_bit(oe_cnt == 1, 1'b1, "one display_oe period per row");
				if (row_addr == '0)
					frames++;
				cur_row   = row_addr;
				col_cnt   = 0;
				latch_cnt = 0;
				oe_cnt    = 0;
			end
		end
		dclk_q  = display_clk;
		latch_q = latch;
		oe_q    = display_oe;
	end

	// game pad model and mosi monitor
	always @(negedge clk) begin
		if (!rst) begin
			if (!cs_n && cs_q) begin
				polls_started++;
				spi_bits  = 0;
				miso_bits = 0;
			end
			if (!cs_n && !spi_clk && spi_q && miso_bits < POLL_BITS) begin
				miso = pad_bytes[miso_bits / 8][miso_bits % 8];   // LSB first
				miso_bits++;
			end
			if (!cs_n && spi_clk && !spi_q) begin
				mosi_byte = {mosi, mosi_byte[7:1]};
				spi_bits++;
				if (spi_bits % 8 == 0 && spi_bits <= POLL_BITS)
					check_byte(mosi_byte, req_bytes[spi_bits / 8 - 1], "mosi request byte");
			end
			if (cs_n && !cs_q) begin
				check_bit(spi_bits == POLL_BITS, 1'b1, "40 spi_clk bits per poll");
				polls_done++;
			end
		end
		cs_q  = cs_n;
		spi_q = spi_clk;
	end

	initial begin
		void'($urandom(39221));
		rst     = 1'b1;
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		miso    = 1'b1;
		req_bytes = '{8'h01, 8'h42, 8'h00, 8'h00, 8'h00};
		pad_bytes = '{default: 8'hff};
		for (int h = 0; h < 2; h++) begin
			for (int i = 0; i < PIX_N; i++) begin
				pix_written[h][i] = 1'b0;
				pix_seen[h][i]    = 1'b0;
			end
		end
		cur_row = '0;
		{col_cnt, latch_cnt, oe_cnt, frames} = '0;
		{polls_started, polls_done, spi_bits, miso_bits} = '0;
		{dclk_q, latch_q, oe_q, spi_q, cs_q} = 5'b00111;

		repeat (2) @(negedge clk);
		check_bit(display_oe, 1'b1, "display_oe in reset");
		check_bit(latch, 1'b0, "latch in reset");
		check_bit(display_clk, 1'b0, "display_clk in reset");
		check_bit(cs_n, 1'b1, "cs_n in reset");
		check_bit(spi_clk, 1'b1, "spi_clk in reset");
		check_bit(pslverr, 1'b0, "pslverr in reset");
		rst = 1'b0;

		replay_trace();
		wait_frames(2);   // every written pixel scanned at least once
		for (int h = 0; h < 2; h++) begin
			for (int i = 0; i < PIX_N; i++) begin
				if (pix_written[h][i] && !pix_seen[h][i])
					stop_on_error($sformatf("written pixel %0d of half %0d never reached the panel",
						i, h));
			end
		end
		$display("Test passed");
		$finish;
	end

endmodule

//--- flist.f
+incdir+src
src/led_matrix_pkg.sv
src/led_matrix_if.sv
src/apb_bus_decode.sv
src/led_framebuffer.sv
src/led_scan_ctrl.sv
src/pad_spi_poller.sv
src/led_matrix_top.sv
bench/led_matrix_chk.sv
bench/tb_led_matrix.sv

//--- run_sim.sh
#!/bin/sh
# builds the LED matrix testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tb_led_matrix -o sim_led_matrix
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_led_matrix > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

echo "simulation run clean"
exit 0

//--- src/apb_bus_decode.sv
//**************************************
// APB slave with no wait states, framebuffer is write only
// addresses are assumed word aligned, byte lanes are ignored
//**************************************
`timescale 1ns/10ps
`include "led_matrix_config.svh"

module apb_bus_decode (
	input  logic                       clk,
	input  logic                       rst,
	input  led_matrix_pkg::apb_addr_t  paddr,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  led_matrix_pkg::apb_data_t  pwdata,
	output led_matrix_pkg::apb_data_t  prdata,
	output logic                       pready,
	output logic                       pslverr,
	fb_wr_if.master                    fb,
	input  led_matrix_pkg::pad_state_t pad_state
);

	led_matrix_pkg::apb_region_e region;
	logic setup;
	logic err;

	assign setup  = psel & ~penable;
	assign pready = 1'b1;

	always_comb begin
		if (paddr[15:14] == 2'b00)   // 0x0000 - 0x3ffc
			region = led_matrix_pkg::REGION_FB;
		else if (paddr == `PAD_REG_ADDR)
			region = led_matrix_pkg::REGION_PAD;
		else
			region = led_matrix_pkg::REGION_NONE;
	end

	// fb is write only, pad register is read only
	assign err = (region == led_matrix_pkg::REGION_NONE) ||
		(region == led_matrix_pkg::REGION_FB && !pwrite) ||
		(region == led_matrix_pkg::REGION_PAD && pwrite);

	// response registered in setup, valid through the access phase
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fb.we   <= 1'b0;
			prdata  <= '0;
			pslverr <= 1'b0;
		end else begin
			fb.we <= setup & pwrite & (region == led_matrix_pkg::REGION_FB);
			if (setup) begin
				pslverr <= err;
				if (region == led_matrix_pkg::REGION_PAD && !pwrite)
					prdata <= {16'b0, pad_state};
				else
					prdata <= '0;   // fb reads and errors return zero
			end
		end
	end

	// pixel address split: bit 13 half, 12..8 row, 7..2 col
	always_ff @(posedge clk) begin
		if (setup) begin
			fb.half <= paddr[13];
			fb.row  <= paddr[12:8];
			fb.col  <= paddr[7:2];
			fb.data <= pwdata[`PIXEL_W-1:0];
		end
	end

endmodule

//--- src/led_framebuffer.sv
//**************************************
// two half-panel pixel memories, power-up contents undefined
//**************************************
`timescale 1ns/10ps
`include "led_matrix_config.svh"

module led_framebuffer (
	input  logic    clk,
	input  logic    rst,
	fb_wr_if.slave  wr,
	pix_rd_if.slave rd
);

	localparam int DEPTH = `LED_ROWS * `LED_COLS;

	led_matrix_pkg::pixel_t mem [2][DEPTH];   // [0] upper, [1] lower
	led_matrix_pkg::pixel_t rd_q [2];
	logic re_d;

	// write port, and first read stage from both halves
	always_ff @(posedge clk) begin
		if (wr.we)
			mem[wr.half][{wr.row, wr.col}] <= wr.data;
		if (rd.re) begin
			rd_q[0] <= mem[0][{rd.row, rd.col}];
			rd_q[1] <= mem[1][{rd.row, rd.col}];
		end
	end

	// second stage, held until the next read completes
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			re_d      <= 1'b0;
			rd.data_a <= '0;
			rd.data_b <= '0;
		end else begin
			re_d <= rd.re;
			if (re_d) begin
				rd.data_a <= rd_q[0];
				rd.data_b <= rd_q[1];
			end
		end
	end

endmodule

//--- src/led_matrix_config.svh
//**************************************
// panel geometry, scan and SPI timing in clk cycles, APB byte address map
// row and column widths follow LED_ROWS and LED_COLS, both powers of two
//**************************************
`ifndef LED_MATRIX_CONFIG_SVH
`define LED_MATRIX_CONFIG_SVH

`define LED_ROWS        32
`define LED_COLS        64
`define PIXEL_W         4

`define LATCH_CYCLES    4
`define OE_CYCLES       8
`define BLANK_CYCLES    6

`define SPI_IDLE_CYCLES 5000   // also sizes the poller wait counter
`define SPI_CS_DELAY    500
`define SPI_HALF_CYCLES 100
`define SPI_BYTE_GAP    1000
`define PAD_REQ_BYTES   5

`define PAD_REG_ADDR    16'h4000

`endif

//--- src/led_matrix_if.sv
//**************************************
// framebuffer write port and pixel read port, no back-pressure on either
//**************************************
`timescale 1ns/10ps

// one pixel write per clock where we is high
interface fb_wr_if;
	logic                  we;
	led_matrix_pkg::half_t half;
	led_matrix_pkg::row_t  row;
	led_matrix_pkg::col_t  col;
	led_matrix_pkg::pixel_t data;

	modport master (output we, half, row, col, data);
	modport slave  (input  we, half, row, col, data);
endinterface

// data_a / data_b appear two cycles after re and hold until the next read
interface pix_rd_if;
	logic                   re;
	led_matrix_pkg::row_t   row;
	led_matrix_pkg::col_t   col;
	led_matrix_pkg::pixel_t data_a;   // upper half
	led_matrix_pkg::pixel_t data_b;   // lower half

	modport master (output re, row, col, input  data_a, data_b);
	modport slave  (input  re, row, col, output data_a, data_b);
endinterface

//--- src/led_matrix_pkg.sv
//**************************************
// shared types for the LED matrix design
//**************************************
`include "led_matrix_config.svh"

package led_matrix_pkg;

	typedef logic [`PIXEL_W-1:0]          pixel_t;
	typedef logic [$clog2(`LED_ROWS)-1:0] row_t;
	typedef logic [$clog2(`LED_COLS)-1:0] col_t;
	typedef logic                         half_t;   // 0 upper, 1 lower
	typedef logic [15:0]                  apb_addr_t;
	typedef logic [31:0]                  apb_data_t;
	typedef logic [15:0]                  pad_state_t;   // 1 = pressed
	typedef logic [7:0]                   spi_byte_t;

	// literals carry a prefix since both machines have clock phases
	typedef enum logic [2:0] {
		SCAN_FETCH, SCAN_DATA_WAIT, SCAN_CLK_HIGH, SCAN_CLK_LOW,
		SCAN_LATCH, SCAN_ENABLE, SCAN_BLANK
	} scan_state_e;

	typedef enum logic [2:0] {
		SPI_IDLE, SPI_CS_DELAY, SPI_CLK_LOW, SPI_CLK_HIGH, SPI_BYTE_GAP
	} spi_state_e;

	typedef enum logic [1:0] {REGION_FB, REGION_PAD, REGION_NONE} apb_region_e;

endpackage

//--- src/led_matrix_top.sv
//**************************************
// LED matrix panel with APB pixel access and SPI game pad polling
//**************************************
`timescale 1ns/10ps

module led_matrix_top (
	input  logic                      clk,
	input  logic                      rst,
	input  led_matrix_pkg::apb_addr_t paddr,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  led_matrix_pkg::apb_data_t pwdata,
	output led_matrix_pkg::apb_data_t prdata,
	output logic                      pready,
	output logic                      pslverr,
	output led_matrix_pkg::row_t      row_addr,
	output led_matrix_pkg::col_t      col_addr,
	output logic                      display_oe,
	output logic                      latch,
	output logic                      display_clk,
	output led_matrix_pkg::pixel_t    dout_a,
	output led_matrix_pkg::pixel_t    dout_b,
	output logic                      spi_clk,
	output logic                      cs_n,
	output logic                      mosi,
	input  logic                      miso
);

	led_matrix_pkg::pad_state_t pad_state;

	fb_wr_if  fb_wr ();
	pix_rd_if pix_rd ();

	apb_bus_decode u_apb (
		.clk(clk), .rst(rst),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.fb(fb_wr.master), .pad_state(pad_state)
	);

	led_framebuffer u_fb (
		.clk(clk), .rst(rst), .wr(fb_wr.slave), .rd(pix_rd.slave)
	);

	led_scan_ctrl u_scan (
		.clk(clk), .rst(rst), .rd(pix_rd.master),
		.row_addr(row_addr), .col_addr(col_addr), .display_oe(display_oe),
		.latch(latch), .display_clk(display_clk), .dout_a(dout_a), .dout_b(dout_b)
	);

	pad_spi_poller u_pad (
		.clk(clk), .rst(rst), .spi_clk(spi_clk), .cs_n(cs_n),
		.mosi(mosi), .miso(miso), .pad_state(pad_state)
	);

endmodule

//--- src/led_scan_ctrl.sv
//**************************************
// panel scan, four clk cycles per column then latch, enable and blank
// display_oe is active low, outputs are decoded from the state
//**************************************
`timescale 1ns/10ps
`include "led_matrix_config.svh"

module led_scan_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	pix_rd_if.master               rd,
	output led_matrix_pkg::row_t   row_addr,
	output led_matrix_pkg::col_t   col_addr,
	output logic                   display_oe,
	output logic                   latch,
	output logic                   display_clk,
	output led_matrix_pkg::pixel_t dout_a,
	output led_matrix_pkg::pixel_t dout_b
);

	led_matrix_pkg::scan_state_e state;
	logic [7:0] cnt;   // latch, enable and blank lengths

	assign rd.re       = (state == led_matrix_pkg::SCAN_FETCH);
	assign rd.row      = row_addr;
	assign rd.col      = col_addr;
	assign display_clk = (state == led_matrix_pkg::SCAN_CLK_HIGH);
	assign latch       = (state == led_matrix_pkg::SCAN_LATCH);
	assign display_oe  = (state != led_matrix_pkg::SCAN_ENABLE);

	// read data lands exactly in CLK_HIGH
	assign dout_a = rd.data_a;
	assign dout_b = rd.data_b;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= led_matrix_pkg::SCAN_FETCH;
			cnt      <= '0;
			row_addr <= '0;
			col_addr <= '0;
		end else begin
			case (state)
				led_matrix_pkg::SCAN_FETCH:     state <= led_matrix_pkg::SCAN_DATA_WAIT;
				led_matrix_pkg::SCAN_DATA_WAIT: state <= led_matrix_pkg::SCAN_CLK_HIGH;
				led_matrix_pkg::SCAN_CLK_HIGH:  state <= led_matrix_pkg::SCAN_CLK_LOW;
				led_matrix_pkg::SCAN_CLK_LOW: begin
					if (col_addr == `LED_COLS - 1) begin
						col_addr <= '0;
						cnt      <= '0;
						state    <= led_matrix_pkg::SCAN_LATCH;
					end else begin
						col_addr <= col_addr + 1'b1;
						state    <= led_matrix_pkg::SCAN_FETCH;
					end
				end
				led_matrix_pkg::SCAN_LATCH: begin
					cnt <= cnt + 1'b1;
					if (cnt == 8'(`LATCH_CYCLES - 1)) begin
						cnt   <= '0;
						state <= led_matrix_pkg::SCAN_ENABLE;
					end
				end
				led_matrix_pkg::SCAN_ENABLE: begin
					cnt <= cnt + 1'b1;
					if (cnt == 8'(`OE_CYCLES - 1)) begin
						cnt   <= '0;
						state <= led_matrix_pkg::SCAN_BLANK;
					end
				end
				led_matrix_pkg::SCAN_BLANK: begin
					cnt <= cnt + 1'b1;
					if (cnt == 8'(`BLANK_CYCLES - 1)) begin
						cnt   <= '0;
						state <= led_matrix_pkg::SCAN_FETCH;
						// next row only once the blank gap is over
						if (row_addr == `LED_ROWS - 1)
							row_addr <= '0;
						else
							row_addr <= row_addr + 1'b1;
					end
				end
				default: state <= led_matrix_pkg::SCAN_FETCH;
			endcase
		end
	end

endmodule

//--- src/pad_spi_poller.sv
//**************************************
// game pad poller, SPI mode 3, LSB first, fixed 5 byte request
// pad bits are active low and are stored inverted
//**************************************
`timescale 1ns/10ps
`include "led_matrix_config.svh"

module pad_spi_poller (
	input  logic                       clk,
	input  logic                       rst,
	output logic                       spi_clk,
	output logic                       cs_n,
	output logic                       mosi,
	input  logic                       miso,
	output led_matrix_pkg::pad_state_t pad_state
);

	localparam int WAIT_W = $clog2(`SPI_IDLE_CYCLES + 1);

	led_matrix_pkg::spi_state_e state;
	logic [WAIT_W-1:0]          wait_cnt;
	logic [2:0]                 bit_cnt;
	logic [2:0]                 byte_cnt;
	led_matrix_pkg::spi_byte_t  tx_byte;
	led_matrix_pkg::spi_byte_t  rx_byte;
	logic [15:0]                rx_word;   // last two bytes received

	// request 01 42 00 00 00
	always_comb begin
		case (byte_cnt)
			3'd0:    tx_byte = 8'h01;
			3'd1:    tx_byte = 8'h42;
			default: tx_byte = 8'h00;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state     <= led_matrix_pkg::SPI_IDLE;
			wait_cnt  <= '0;
			bit_cnt   <= '0;
			byte_cnt  <= '0;
			spi_clk   <= 1'b1;
			cs_n      <= 1'b1;
			mosi      <= 1'b0;
			pad_state <= '0;
		end else begin
			wait_cnt <= wait_cnt + 1'b1;
			case (state)
				led_matrix_pkg::SPI_IDLE: begin
					if (wait_cnt == WAIT_W'(`SPI_IDLE_CYCLES - 1)) begin
						wait_cnt <= '0;
						cs_n     <= 1'b0;
						state    <= led_matrix_pkg::SPI_CS_DELAY;
					end
				end
				led_matrix_pkg::SPI_CS_DELAY: begin
					if (wait_cnt == WAIT_W'(`SPI_CS_DELAY - 1)) begin
						wait_cnt <= '0;
						spi_clk  <= 1'b0;
						mosi     <= tx_byte[0];
						state    <= led_matrix_pkg::SPI_CLK_LOW;
					end
				end
				led_matrix_pkg::SPI_CLK_LOW: begin
					if (wait_cnt == WAIT_W'(`SPI_HALF_CYCLES - 1)) begin
						wait_cnt <= '0;
						spi_clk  <= 1'b1;
						state    <= led_matrix_pkg::SPI_CLK_HIGH;
					end
				end
				led_matrix_pkg::SPI_CLK_HIGH: begin
					if (wait_cnt == '0)
						rx_byte <= {miso, rx_byte[7:1]};   // one cycle after rise
					if (wait_cnt == WAIT_W'(`SPI_HALF_CYCLES - 1)) begin
						wait_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							byte_cnt <= byte_cnt + 1'b1;   // points at the next byte in the gap
							rx_word  <= {rx_word[7:0], rx_byte};
							state    <= led_matrix_pkg::SPI_BYTE_GAP;
						end else begin
							spi_clk <= 1'b0;
							mosi    <= tx_byte[bit_cnt + 3'd1];
							state   <= led_matrix_pkg::SPI_CLK_LOW;
						end
					end
				end
				led_matrix_pkg::SPI_BYTE_GAP: begin
					if (wait_cnt == WAIT_W'(`SPI_BYTE_GAP - 1)) begin
						wait_cnt <= '0;
						if (byte_cnt == 3'(`PAD_REQ_BYTES)) begin
							byte_cnt  <= '0;
							cs_n      <= 1'b1;
							mosi      <= 1'b0;
							pad_state <= ~rx_word;   // {byte3, byte4}
							state     <= led_matrix_pkg::SPI_IDLE;
						end else begin
							spi_clk <= 1'b0;
							mosi    <= tx_byte[0];
							state   <= led_matrix_pkg::SPI_CLK_LOW;
						end
					end
				end
				default: state <= led_matrix_pkg::SPI_IDLE;
			endcase
		end
	end

endmodule
